// File: compile.f
+incdir+test
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/instrFetch.sv
verilog/instrDecode.sv
verilog/regFile.sv
verilog/operandForward.sv
verilog/executeUnit.sv
verilog/pipelinedCpu.sv
test/cpuTb.sv

// File: Makefile
SOURCES = $(wildcard verilog/*.sv) test/cpuTb.sv test/cpuTests.svh

.PHONY: run clean

run: obj_dir/VcpuTb
	@out="$$(./obj_dir/VcpuTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

obj_dir/VcpuTb: compile.f $(SOURCES)
	verilator --binary --timing --assert --top-module cpuTb -f compile.f

clean:
	rm -rf obj_dir

// File: test/cpuTests.svh
// ************************************************************************
// directed tests where each program stores what it computes
// ************************************************************************

// ALU chain with every result used by the very next instruction
task automatic arithmeticTest();
	logic [11:0] i1;
	logic [11:0] i2;
	shamt_t      sh;
	word_t       x [1:7];
	beginTest("arithmetic");
	i1   = 12'(randBits(12));
	i2   = 12'(randBits(12));
	sh   = shamt_t'(randBits(6));
	x[1] = word_t'(i1);
	x[2] = x[1] + word_t'(i2);
	x[3] = x[2] + x[1];
	x[4] = x[1] - x[3];  // goes negative
	x[5] = x[4] & x[3];
	x[6] = x[5] ^ x[4];
	x[7] = x[6] >> sh;   // zeros shifted in
	put(addiInstr(5'd10, zeroReg, 12'h100)); // store base
	put(addiInstr(5'd1, zeroReg, i1));
	put(addiInstr(5'd2, 5'd1, i2));
	put(rInstr(opAdds, 5'd3, 5'd2, 5'd1, '0));
	put(rInstr(opSubs, 5'd4, 5'd1, 5'd3, '0));
	put(rInstr(opAnd, 5'd5, 5'd4, 5'd3, '0));
	put(rInstr(opEor, 5'd6, 5'd5, 5'd4, '0));
	put(rInstr(opLsr, 5'd7, 5'd6, 5'd0, sh));
	for (int k = 1; k <= 7; k++) begin
		put(memInstr(opStur, regIdx_t'(k), 5'd10, 9'(8 * (k - 1))));
		expectStore(64'h100 + word_t'(8 * (k - 1)), x[k]);
	end
	runProgram();
endtask

// loads used two instructions later and never right after
task automatic loadStoreTest();
	logic [11:0] r1;
	logic [11:0] r2;
	logic [11:0] r3;
	logic [11:0] r4;
	beginTest("load store");
	r1 = 12'(randBits(12));
	r2 = 12'(randBits(12));
	r3 = 12'(randBits(12));
	r4 = 12'(randBits(12));
	put(addiInstr(5'd10, zeroReg, 12'h200));
	put(addiInstr(5'd1, zeroReg, r1));
	put(addiInstr(5'd2, zeroReg, r2));
	put(memInstr(opStur, 5'd1, 5'd10, 9'd0));
	put(memInstr(opStur, 5'd2, 5'd10, 9'd8));
	put(addiInstr(5'd9, zeroReg, 12'd1)); // spacer
	put(memInstr(opLdur, 5'd3, 5'd10, 9'd0));
	put(memInstr(opLdur, 5'd4, 5'd10, 9'd8));
	put(addiInstr(5'd5, 5'd3, r3));
	put(addiInstr(5'd6, 5'd4, r4));
	put(memInstr(opLdur, 5'd7, 5'd10, 9'd32)); // untouched background word
	put(memInstr(opStur, 5'd5, 5'd10, 9'd16));
	put(memInstr(opStur, 5'd7, 5'd10, 9'd40)); // store data straight from load
	put(memInstr(opStur, 5'd6, 5'd10, 9'd24));
	expectStore(64'h200, word_t'(r1));
	expectStore(64'h208, word_t'(r2));
	expectStore(64'h210, word_t'(r1) + word_t'(r3));
	expectStore(64'h228, fillWord(64'h220));
	expectStore(64'h218, word_t'(r2) + word_t'(r4));
	runProgram();
endtask

// XZR drops writes and must not be forwarded
task automatic zeroRegTest();
	logic [11:0] lost;
	logic [11:0] r;
	beginTest("zero register");
	lost = 12'(randBits(12)) | 12'd1;
	r    = 12'(randBits(12));
	put(addiInstr(zeroReg, zeroReg, lost));
	put(addiInstr(5'd1, zeroReg, r));
	put(rInstr(opAdds, zeroReg, 5'd1, 5'd1, '0));
	put(rInstr(opAdds, 5'd2, 5'd1, zeroReg, '0));
	put(memInstr(opStur, 5'd2, zeroReg, 9'd64)); // base XZR reads as 0
	put(memInstr(opStur, zeroReg, zeroReg, 9'd72));
	expectStore(64'd64, word_t'(r));
	expectStore(64'd72, '0);
	runProgram();
endtask

task automatic branchTest();
	logic [11:0] r;
	beginTest("branch");
	r = 12'(randBits(12));
	put(addiInstr(5'd10, zeroReg, 12'h300));
	put(addiInstr(5'd1, zeroReg, r));
	put(branchInstr(26'd4));                  // over two stores
	put(memInstr(opStur, 5'd1, 5'd10, 9'd0)); // delay slot
	put(memInstr(opStur, 5'd1, 5'd10, 9'd8));
	put(memInstr(opStur, 5'd1, 5'd10, 9'd16));
	put(memInstr(opStur, 5'd1, 5'd10, 9'd24)); // target
	expectStore(64'h300, word_t'(r));
	expectStore(64'h318, word_t'(r));
	runProgram();
endtask

// SUBS then B.LT over one store with the outcome from the signed compare
function automatic void bltCase(regIdx_t dst, regIdx_t srcA, regIdx_t srcB, word_t valA,
	word_t valB, logic spaced, logic [8:0] off);
	word_t diff;
	logic  lt;
	diff = valA - valB;
	lt   = $signed(valA) < $signed(valB);
	put(rInstr(opSubs, dst, srcA, srcB, '0));
	if (spaced) begin
		put(addiInstr(5'd8, zeroReg, 12'd7)); // flags come from the register
	end
	put(bltInstr(19'd3));
	put(memInstr(opStur, dst, 5'd10, off));
	put(memInstr(opStur, dst, 5'd10, off + 9'd8));
	expectStore(64'h400 + word_t'(off), diff);
	if (!lt) begin
		expectStore(64'h400 + word_t'(off + 9'd8), diff);
	end
endfunction

task automatic condBranchTest();
	logic [11:0] r;
	word_t       b;
	beginTest("conditional");
	r = 12'(randBits(12)) | 12'd1; // never zero
	b = word_t'(r);
	put(addiInstr(5'd1, zeroReg, 12'd5));          // file holds non-zero X1
	put(addiInstr(5'd10, zeroReg, 12'h400));
	put(addiInstr(5'd2, zeroReg, r));
	put(rInstr(opSubs, 5'd11, zeroReg, 5'd2, '0)); // X11 = -r
	put(addiInstr(5'd1, zeroReg, 12'd0));
	put(cbzInstr(5'd1, 19'd3));                    // taken on a forwarded zero
	put(memInstr(opStur, 5'd2, 5'd10, 9'd0));
	put(memInstr(opStur, 5'd2, 5'd10, 9'd8));
	put(cbzInstr(5'd2, 19'd3));                    // falls through
	put(memInstr(opStur, 5'd2, 5'd10, 9'd16));
	put(memInstr(opStur, 5'd2, 5'd10, 9'd24));
	put(addiInstr(5'd3, 5'd2, 12'd1));
	put(cbzInstr(5'd3, 19'd3));                    // forwarded and not zero
	put(memInstr(opStur, 5'd3, 5'd10, 9'd32));
	put(memInstr(opStur, 5'd3, 5'd10, 9'd40));
	expectStore(64'h400, b);
	expectStore(64'h410, b);
	expectStore(64'h418, b);
	expectStore(64'h420, b + 64'd1);
	expectStore(64'h428, b + 64'd1);
	bltCase(5'd4, 5'd1, 5'd2, '0, b, 1'b0, 9'd48);
	bltCase(5'd5, 5'd2, 5'd1, b, '0, 1'b1, 9'd64);
	bltCase(5'd6, 5'd11, 5'd2, -b, b, 1'b1, 9'd80);
	bltCase(5'd7, 5'd2, 5'd11, b, -b, 1'b0, 9'd96);
	runProgram();
endtask

// fetch restarts at 0 and the strobe stays low until the first store is in MEM
task automatic resetTest();
	logic [11:0] r;
	beginTest("reset");
	r = 12'(randBits(12));
	put(addiInstr(5'd1, zeroReg, r));
	put(addiInstr(5'd10, zeroReg, 12'h600));
	put(memInstr(opStur, 5'd1, 5'd10, 9'd0)); // slot 2 reaches MEM three cycles on
	expectStore(64'h600, word_t'(r));
	releaseReset();
	compareAddr("first fetch", '0, instrAddr);
	for (int m = 0; m <= 5; m++) begin
		if (m > 0) begin
			@(negedge clk);
		end
		if (m == 1) begin
			compareAddr("second fetch", 64'd4, instrAddr);
		end
		compareBit($sformatf("store strobe at edge %0d", m), m == 5, dataWriteEn);
	end
	waitForLoop();
	checkStores();
endtask

// File: test/cpuTb.sv
`timescale 1ns/1ps

module cpuTb import isaPkg::*; ();

	localparam int memWords      = 256;
	localparam int testCount     = 6;
	localparam int cyclesPerTest = 400;
	localparam int cycleLimit    = testCount * cyclesPerTest; // whole run

	logic   clk;
	logic   rst;
	word_t  instrAddr;
	instr_t instr;
	word_t  dataAddr;
	word_t  dataWrite;
	logic   dataWriteEn;
	word_t  dataRead;

	instr_t imem [memWords];
	word_t  dmem [memWords];

	word_t expAddr [$]; // stores the program should make
	word_t expData [$];
	word_t gotAddr [$]; // stores seen on the data port
	word_t gotData [$];

	string       testName;
	int          progLen;   // next free instruction slot
	word_t       loopAddr;  // address of the closing self loop
	int          cycles = 0;
	logic [31:0] lfsr   = 32'h199f;

	pipelinedCpu pipelinedCpu_i (
		.clk         (clk),
		.rst         (rst),
		.instrAddr   (instrAddr),
		.instr       (instr),
		.dataAddr    (dataAddr),
		.dataWrite   (dataWrite),
		.dataWriteEn (dataWriteEn),
		.dataRead    (dataRead)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ************************************************************************
	// memory models
	// ************************************************************************

	assign instr    = imem[instrAddr[9:2]];  // word index
	assign dataRead = dmem[dataAddr[10:3]]; // doubleword index

	// store commits between rising edges, also logged in order
	always @(negedge clk) begin
		if (!rst && dataWriteEn) begin
			dmem[dataAddr[10:3]] = dataWrite;
			gotAddr.push_back(dataAddr);
			gotData.push_back(dataWrite);
		end
	end

	// background contents, distinct for every address
	function automatic word_t fillWord(word_t addr);
		return {addr[31:0] ^ 32'hc0de_f00d, ~addr[31:0]};
	endfunction

	function automatic void clearMemories();
		for (int i = 0; i < memWords; i++) begin
			imem[8'(i)] = '0; // all-zero word decodes as nop
			dmem[8'(i)] = fillWord(word_t'(i) << 3);
		end
	endfunction

	// ************************************************************************
	// failure reporting and checks
	// ************************************************************************

	task automatic stopOnFailure(string why);
		$display("%s", why);
		$display("RESULT: FAIL");
		$fatal(1, "stopped at first failure");
	endtask

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			stopOnFailure($sformatf("timeout: no end of test %s after %0d cycles",
				testName, cycles));
		end
	end

	task automatic compareWord(string what, word_t exp, word_t act);
		if (act !== exp) begin
			stopOnFailure($sformatf("Error %s %s: expected %h, actual %h",
				testName, what, exp, act));
		end
	endtask

	task automatic compareAddr(string what, word_t exp, word_t act);
		if (act !== exp) begin
			stopOnFailure($sformatf("Error %s %s address: expected %h, actual %h",
				testName, what, exp, act));
		end
	endtask

	task automatic compareBit(string what, logic exp, logic act);
		if (act !== exp) begin
			stopOnFailure($sformatf("Error %s %s: expected %b, actual %b",
				testName, what, exp, act));
		end
	endtask

	task automatic checkStores();
		if (gotAddr.size() != expAddr.size()) begin
			stopOnFailure($sformatf("Error %s store count: expected %0d, actual %0d",
				testName, expAddr.size(), gotAddr.size()));
		end
		for (int i = 0; i < expAddr.size(); i++) begin
			compareAddr($sformatf("store %0d", i), expAddr[i], gotAddr[i]);
			compareWord($sformatf("store %0d data", i), expData[i], gotData[i]);
		end
	endtask

	// ************************************************************************
	// random immediates and instruction encoding
	// ************************************************************************

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
	function automatic logic [63:0] randBits(int n);
		logic [63:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[62:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic instr_t rInstr(logic [10:0] op, regIdx_t rd, regIdx_t rn,
		regIdx_t rm, shamt_t sh);
		return {op, rm, sh, rn, rd};
	endfunction

	function automatic instr_t addiInstr(regIdx_t rd, regIdx_t rn, logic [11:0] imm);
		return {opAddi, imm, rn, rd};
	endfunction

	// LDUR / STUR, op2 field left zero
	function automatic instr_t memInstr(logic [10:0] op, regIdx_t rt, regIdx_t rn,
		logic [8:0] off);
		return {op, off, 2'b00, rn, rt};
	endfunction

	function automatic instr_t branchInstr(logic [25:0] off);
		return {opB, off};
	endfunction

	function automatic instr_t cbzInstr(regIdx_t rt, logic [18:0] off);
		return {opCbz, off, rt};
	endfunction

	function automatic instr_t bltInstr(logic [18:0] off);
		return {opBlt, off, 5'b01011}; // cond LT
	endfunction

	// ************************************************************************
	// program flow
	// ************************************************************************

	function automatic void put(instr_t w);
		imem[8'(progLen)] = w;
		progLen++;
	endfunction

	function automatic void expectStore(word_t addr, word_t data);
		expAddr.push_back(addr);
		expData.push_back(data);
	endfunction

	// holds the core in reset while the new program goes in
	task automatic beginTest(string name);
		@(negedge clk);
		rst      = 1'b1;
		testName = name;
		progLen  = 0;
		clearMemories();
		expAddr.delete();
		expData.delete();
		gotAddr.delete();
		gotData.delete();
	endtask

	task automatic releaseReset();
		put(branchInstr('0)); // self loop ends every program
		put('0);              // and its delay slot
		loopAddr = word_t'((progLen - 2) * instrBytes);
		repeat (5) @(negedge clk);
		rst = 1'b0;
	endtask

	// third visit of the loop, every earlier store is through MEM by then
	task automatic waitForLoop();
		int visits;
		visits = 0;
		while (visits < 3) begin
			@(negedge clk);
			if (instrAddr == loopAddr) begin
				visits++;
			end
		end
	endtask

	task automatic runProgram();
		releaseReset();
		waitForLoop();
		checkStores();
	endtask

	`include "cpuTests.svh"

	initial begin
		rst = 1'b1;
		clearMemories();
		arithmeticTest();
		loadStoreTest();
		zeroRegTest();
		branchTest();
		condBranchTest();
		resetTest();
		$display("RESULT: PASS");
		$finish;
	end

endmodule

// File: verilog/pipelinedCpu.sv
`timescale 1ns/1ps

module pipelinedCpu import isaPkg::*, pipePkg::*; (
	input  logic   clk,
	input  logic   rst,
	output word_t  instrAddr,   // instruction side
	input  instr_t instr,
	output word_t  dataAddr,    // data side
	output word_t  dataWrite,
	output logic   dataWriteEn,
	input  word_t  dataRead
);

	typedef struct packed {
		instr_t instr;
		word_t  pc;     // for branch targets
	} ifId_t;

	ifId_t   ifId;
	idEx_t   idEx;
	idEx_t   idExNext;
	idEx_t   idExFwd;   // idEx with forwarded operands
	exMem_t  exMem;
	exMem_t  exMemNext;
	memWb_t  memWb;
	memWb_t  memWbNext;

	logic    branchTaken;
	word_t   branchTarget;
	ctrl_t   idCtrl;
	word_t   idImm;
	regIdx_t idRn;
	regIdx_t idRm;
	regIdx_t idRd;
	word_t   fileA;
	word_t   fileB;
	word_t   idOpA;
	word_t   idOpB;
	word_t   exOpA;
	word_t   exOpB;
	word_t   exResult;
	flags_t  flagsNext;
	word_t   wbData;

	// ************************************************************************
	// fetch
	// ************************************************************************

	instrFetch fetch_i (
		.clk          (clk),
		.rst          (rst),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget),
		.pc           (instrAddr)
	);

	// ************************************************************************
	// decode and register read
	// ************************************************************************

	instrDecode decode_i (
		.instr        (ifId.instr),
		.pc           (ifId.pc),
		.flags        (flagsNext),
		.cbzValue     (idOpB),      // CBZ sees forwarded Rt
		.ctrl         (idCtrl),
		.imm          (idImm),
		.rn           (idRn),
		.rm           (idRm),
		.rd           (idRd),
		.branchTaken  (branchTaken),
		.branchTarget (branchTarget)
	);

	regFile regFile_i (
		.clk   (clk),
		.rst   (rst),
		.readA (idRn),
		.readB (idRm),
		.dataA (fileA),
		.dataB (fileB),
		.wb    (memWb)
	);

	// producers in EX and MEM while the regfile bypass covers writeback
	operandForward idForward_i (
		.srcA   (idRn),
		.srcB   (idRm),
		.fileA  (fileA),
		.fileB  (fileB),
		.exFwd  (exMemNext),
		.memFwd (memWbNext),
		.opA    (idOpA),
		.opB    (idOpB)
	);

	always_comb begin
		idExNext.ctrl  = idCtrl;
		idExNext.a     = idOpA;
		idExNext.b     = idOpB;
		idExNext.imm   = idImm;
		idExNext.rd    = idRd;
		idExNext.shamt = ifId.instr[shamtLsb +: $bits(shamt_t)];
		idExNext.rn    = idRn;
		idExNext.rm    = idRm;
	end

	// ************************************************************************
	// execute
	// ************************************************************************

	// second look at MEM and WB where a load just ahead still gives its address
	operandForward exForward_i (
		.srcA   (idEx.rn),
		.srcB   (idEx.rm),
		.fileA  (idEx.a),
		.fileB  (idEx.b),
		.exFwd  (exMem),
		.memFwd (memWb),
		.opA    (exOpA),
		.opB    (exOpB)
	);

	always_comb begin
		idExFwd   = idEx;
		idExFwd.a = exOpA;
		idExFwd.b = exOpB;
	end

	executeUnit execute_i (
		.clk       (clk),
		.rst       (rst),
		.idEx      (idExFwd),
		.result    (exResult),
		.flagsNext (flagsNext),
		.flags     ()
	);

	assign exMemNext = '{ctrl: idEx.ctrl, result: exResult, storeData: exOpB, rd: idEx.rd};

	// ************************************************************************
	// memory and writeback select
	// ************************************************************************

	assign dataAddr    = exMem.result;
	assign dataWrite   = exMem.storeData;
	assign dataWriteEn = exMem.ctrl.memWrite;

	assign wbData    = exMem.ctrl.memToReg ? dataRead : exMem.result;
	assign memWbNext = '{regWrite: exMem.ctrl.regWrite, data: wbData, rd: exMem.rd};

	// stage registers all cleared so nothing writes after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			ifId  <= '0;
			idEx  <= '0;
			exMem <= '0;
			memWb <= '0;
		end else begin
			ifId  <= '{instr: instr, pc: instrAddr};
			idEx  <= idExNext;
			exMem <= exMemNext;
			memWb <= memWbNext;
		end
	end

	// no store can reach the data port straight out of reset
	noStoreAfterRst: assert property (@(posedge clk) rst |=> !dataWriteEn);

endmodule

// File: verilog/executeUnit.sv
`timescale 1ns/1ps

module executeUnit import isaPkg::*, pipePkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  idEx_t  idEx,      // operands already forwarded
	output word_t  result,
	output flags_t flagsNext, // what B.LT in decode should see
	output flags_t flags
);

	word_t  bOp;
	word_t  sum;
	word_t  diff;
	flags_t fresh;

	// ************************************************************************
	// ALU
	// ************************************************************************

	always_comb begin
		bOp  = idEx.ctrl.aluSrcImm ? idEx.imm : idEx.b;
		sum  = idEx.a + bOp;
		diff = idEx.a - bOp;
		case (idEx.ctrl.aluOp)
			passB:   result = bOp;
			add:     result = sum;
			sub:     result = diff;
			andOp:   result = idEx.a & bOp;
			xorOp:   result = idEx.a ^ bOp;
			lsr:     result = idEx.a >> idEx.shamt; // logical, zeros in
			default: result = '0;
		endcase
	end

	// ************************************************************************
	// N and V flags
	// ************************************************************************

	always_comb begin
		fresh.n = result[63];
		if (idEx.ctrl.aluOp == sub) begin
			// operands of opposite sign, result sign flipped from a
			fresh.v = (idEx.a[63] != bOp[63]) && (diff[63] != idEx.a[63]);
		end else begin
			fresh.v = (idEx.a[63] == bOp[63]) && (sum[63] != idEx.a[63]);
		end
		flagsNext = idEx.ctrl.setFlags ? fresh : flags; // bypass to decode
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			flags <= '0;
		end else if (idEx.ctrl.setFlags) begin // ADDS / SUBS only
			flags <= fresh;
		end
	end

endmodule

// File: verilog/operandForward.sv
`timescale 1ns/1ps

module operandForward import isaPkg::*, pipePkg::*; (
	input  regIdx_t srcA,
	input  regIdx_t srcB,
	input  word_t   fileA,   // value without forwarding
	input  word_t   fileB,
	input  exMem_t  exFwd,   // nearer producer
	input  memWb_t  memFwd,  // one stage further back
	output word_t   opA,
	output word_t   opB
);

	// newest writer of src wins and XZR is never forwarded
	function automatic word_t pick(regIdx_t src, word_t fileVal);
		if (exFwd.ctrl.regWrite && exFwd.rd != zeroReg && exFwd.rd == src) begin
			return exFwd.result;
		end
		if (memFwd.regWrite && memFwd.rd != zeroReg && memFwd.rd == src) begin
			return memFwd.data;
		end
		return fileVal;
	endfunction

	always_comb begin
		opA = pick(srcA, fileA);
		opB = pick(srcB, fileB);
		// an XZR source keeps the zero from the register file
		fwdZeroA: assert ((srcA !== zeroReg) || (opA === '0));
		fwdZeroB: assert ((srcB !== zeroReg) || (opB === '0));
	end

endmodule

// File: verilog/regFile.sv
`timescale 1ns/1ps

module regFile import isaPkg::*, pipePkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  regIdx_t readA,
	input  regIdx_t readB,
	output word_t   dataA,
	output word_t   dataB,
	input  memWb_t  wb       // write port from writeback
);

	word_t regs [32];

	// write first, a read of the register being written sees the new value
	function automatic word_t readPort(regIdx_t idx);
		if (idx == zeroReg) begin
			return '0;
		end
		if (wb.regWrite && wb.rd == idx) begin
			return wb.data; // bypass the array
		end
		return regs[idx];
	endfunction

	always_comb begin
		dataA = readPort(readA);
		dataB = readPort(readB);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.regWrite && wb.rd != zeroReg) begin // XZR drops writes
			regs[wb.rd] <= wb.data;
		end
	end

endmodule

// File: verilog/instrDecode.sv
`timescale 1ns/1ps

module instrDecode import isaPkg::*, pipePkg::*; (
	input  instr_t  instr,
	input  word_t   pc,           // address of the instruction in decode
	input  flags_t  flags,        // already includes a flag update from EX
	input  word_t   cbzValue,     // forwarded second operand
	output ctrl_t   ctrl,
	output word_t   imm,
	output regIdx_t rn,
	output regIdx_t rm,           // second read index, rd for STUR / CBZ
	output regIdx_t rd,
	output logic    branchTaken,
	output word_t   branchTarget
);

	logic [5:0]  op6;
	logic [7:0]  op8;
	logic [9:0]  op10;
	logic [10:0] op11;
	logic        isB;
	logic        isCbz;
	logic        isBlt;
	logic        useRd;   // read Rt instead of Rm
	word_t       brOffset;

	assign op6  = instr[31 -: 6];
	assign op8  = instr[31 -: 8];
	assign op10 = instr[31 -: 10];
	assign op11 = instr[31 -: 11];

	// ************************************************************************
	// opcode table, shortest opcode checked first
	// ************************************************************************

	always_comb begin
		ctrl  = ctrlNop; // unknown words fall out as a nop
		imm   = '0;
		isB   = 1'b0;
		isCbz = 1'b0;
		isBlt = 1'b0;
		useRd = 1'b0;
		if (op6 == opB) begin
			isB = 1'b1;
		end else if (op8 == opCbz) begin
			isCbz = 1'b1;
			useRd = 1'b1; // tested register sits in Rt
		end else if (op8 == opBlt) begin
			isBlt = 1'b1;
		end else if (op10 == opAddi) begin
			ctrl.regWrite  = 1'b1;
			ctrl.aluSrcImm = 1'b1;
			ctrl.aluOp     = add;
			imm            = word_t'(instr[imm12Lsb +: 12]); // zero extended
		end else begin
			case (op11)
				opAdds: begin
					ctrl.regWrite = 1'b1;
					ctrl.setFlags = 1'b1;
					ctrl.aluOp    = add;
				end
				opSubs: begin
					ctrl.regWrite = 1'b1;
					ctrl.setFlags = 1'b1;
					ctrl.aluOp    = sub;
				end
				opAnd: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluOp    = andOp;
				end
				opEor: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluOp    = xorOp;
				end
				opLsr: begin
					ctrl.regWrite = 1'b1;
					ctrl.aluOp    = lsr; // amount from shamt, carried by the top
				end
				opLdur: begin
					ctrl.regWrite  = 1'b1;
					ctrl.memToReg  = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.aluOp     = add; // base + imm9
					imm            = word_t'(signed'(instr[imm9Lsb +: 9]));
				end
				opStur: begin
					ctrl.memWrite  = 1'b1;
					ctrl.aluSrcImm = 1'b1;
					ctrl.aluOp     = add;
					imm            = word_t'(signed'(instr[imm9Lsb +: 9]));
					useRd          = 1'b1; // store data from Rt
				end
				default: begin
				end
			endcase
		end
	end

	assign rn = instr[rnLsb +: 5];
	assign rd = instr[rdLsb +: 5];
	assign rm = useRd ? rd : instr[rmLsb +: 5];

	// ************************************************************************
	// branch decision and target
	// ************************************************************************

	assign brOffset = isB ? word_t'(signed'(instr[imm26Lsb +: 26]))
	                      : word_t'(signed'(instr[imm19Lsb +: 19]));

	assign branchTarget = pc + (brOffset << 2); // word offset to bytes
	assign branchTaken  = isB
	                    | (isCbz & (cbzValue == '0))
	                    | (isBlt & (flags.n ^ flags.v)); // signed less than

endmodule

// File: verilog/instrFetch.sv
`timescale 1ns/1ps

module instrFetch import isaPkg::*; (
	input  logic  clk,
	input  logic  rst,
	input  logic  branchTaken,
	input  word_t branchTarget,
	output word_t pc
);

	word_t pcNext;

	// branch decided in decode wins over the sequential step
	always_comb begin
		if (branchTaken) begin
			pcNext = branchTarget;
		end else begin
			pcNext = pc + word_t'(instrBytes);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0; // first fetch from address 0
		end else begin
			pc <= pcNext;
		end
	end

	// targets come from decode as pc + offset*4, so the low bits stay clear
	pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

// File: verilog/pipePkg.sv
package pipePkg;

	import isaPkg::*;

	// ALU function select
	typedef enum logic [2:0] {
		passB,
		add,
		sub,
		andOp,
		xorOp,
		lsr
	} aluOp_e;

	// control bits that ride along the pipe
	typedef struct packed {
		logic   regWrite;
		logic   memWrite;
		logic   memToReg;  // writeback takes load data
		logic   aluSrcImm; // b operand is the immediate
		logic   setFlags;  // ADDS / SUBS
		aluOp_e aluOp;
	} ctrl_t;

	localparam ctrl_t ctrlNop = '0; // no writes of any kind

	// decode -> execute
	typedef struct packed {
		ctrl_t   ctrl;
		word_t   a;
		word_t   b;     // also the store data for STUR
		word_t   imm;
		regIdx_t rd;
		shamt_t  shamt;
		regIdx_t rn;    // source indices kept for EX forwarding
		regIdx_t rm;
	} idEx_t;

	// execute -> memory
	typedef struct packed {
		ctrl_t   ctrl;
		word_t   result;    // ALU value or memory address
		word_t   storeData;
		regIdx_t rd;
	} exMem_t;

	// memory -> writeback, also the regfile write port
	typedef struct packed {
		logic    regWrite;
		word_t   data;
		regIdx_t rd;
	} memWb_t;

	typedef struct packed {
		logic n;
		logic v;
	} flags_t;

endpackage

// File: verilog/isaPkg.sv
package isaPkg;

	// ************************************************************************
	// word types
	// ************************************************************************

	typedef logic [63:0] word_t;   // data value, also addresses
	typedef logic [31:0] instr_t;  // one instruction word
	typedef logic [4:0]  regIdx_t; // register number
	typedef logic [5:0]  shamt_t;  // LSR shift amount

	// ************************************************************************
	// opcodes, matched from the top bits of the word
	// ************************************************************************

	localparam logic [5:0]  opB    = 6'b000101;      // B, imm26
	localparam logic [7:0]  opCbz  = 8'b10110100;    // CBZ, imm19
	localparam logic [7:0]  opBlt  = 8'b01010100;    // B.cond, LT only
	localparam logic [9:0]  opAddi = 10'b1001000100; // imm12 unsigned

	// R-type and D-type, 11 bits
	localparam logic [10:0] opAdds = 11'b10101011000;
	localparam logic [10:0] opSubs = 11'b11101011000;
	localparam logic [10:0] opAnd  = 11'b10001010000;
	localparam logic [10:0] opEor  = 11'b11001010000;
	localparam logic [10:0] opLsr  = 11'b11010011010;
	localparam logic [10:0] opLdur = 11'b11111000010;
	localparam logic [10:0] opStur = 11'b11111000000;

	// ************************************************************************
	// field positions, lsb of each field
	// ************************************************************************

	localparam int rdLsb    = 0;  // Rd / Rt
	localparam int rnLsb    = 5;
	localparam int rmLsb    = 16;
	localparam int shamtLsb = 10;
	localparam int imm9Lsb  = 12; // D-type address offset
	localparam int imm12Lsb = 10; // ADDI
	localparam int imm19Lsb = 5;  // CB-type
	localparam int imm26Lsb = 0;  // B-type

	// XZR, reads zero and drops writes
	localparam regIdx_t zeroReg = 5'd31;

	localparam int instrBytes = 4; // sequential PC step

endpackage
